//--- source/chacha_pkg.sv
package chacha_pkg;

  // one stream beat carries exactly one 64-byte chacha block
  localparam int data_w = 512;
  localparam int cfg_w = 32;

  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  // configuration opcodes, bits 31:28 of a config word
  localparam logic [3:0] op_key = 4'h1;
  localparam logic [3:0] op_nonce = 4'h2;
  localparam logic [3:0] op_ctr = 4'h3;
  localparam logic [3:0] op_rounds = 4'h4;

  // number of 16-bit halves per loadable field
  localparam int key_halves = 16;
  localparam int nonce_halves = 6;
  localparam int ctr_halves = 2;

  localparam logic [4:0] rounds_default = 5'd8;

  // "expand 32-byte k", word 0 in the low bits
  localparam logic [3:0][31:0] chacha_sigma = {
    32'h6b206574, 32'h79622d32, 32'h3320646e, 32'h61707865
  };

  typedef struct packed {
    logic [data_w-1:0] tdata;
    logic              tlast;
  } stream_beat_t;

  typedef struct packed {
    logic [3:0]  opcode;
    logic [4:0]  half_idx;
    logic [6:0]  spare;
    logic [15:0] half_val;
  } load_fmt_t;

  typedef struct packed {
    logic [3:0]          opcode;
    logic [4:0]          rounds;
    logic [cfg_w-10:0]   spare;
  } ctrl_fmt_t;

  typedef union packed {
    load_fmt_t load_fmt;
    ctrl_fmt_t ctrl_fmt;
  } cfg_word_t;

  typedef struct packed {
    logic [255:0] key;
    logic [95:0]  nonce;
    logic [4:0]   rounds;
  } chacha_key_t;

endpackage

//--- source/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo (
  input  logic                     aclk,
  input  logic                     arst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  chacha_pkg::stream_beat_t in_beat,
  output logic                     out_valid,
  input  logic                     out_ready,
  output chacha_pkg::stream_beat_t out_beat
);

  chacha_pkg::stream_beat_t mem [chacha_pkg::fifo_depth];

  logic [chacha_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [chacha_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic [chacha_pkg::fifo_ptr_w:0]   count;
  logic                              push;
  logic                              pop;

  assign in_ready = (count != chacha_pkg::fifo_depth);
  assign out_valid = (count != '0);
  assign out_beat = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // pointers wrap since the depth is a power of two
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  a_no_overflow: assert property (@(posedge aclk) disable iff (!arst_n)
    count <= chacha_pkg::fifo_depth)
    else $error("stream_fifo occupancy out of range");

  a_out_stable: assert property (@(posedge aclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("stream_fifo output changed before transfer");

endmodule

//--- source/chacha_cfg_decode.sv
`timescale 1ns/10ps

module chacha_cfg_decode (
  input  logic                    aclk,
  input  logic                    arst_n,
  input  logic                    cfg_valid,
  input  chacha_pkg::cfg_word_t   cfg_word,
  output chacha_pkg::chacha_key_t key_state,
  output logic                    ctr_load,
  output logic [31:0]             ctr_value,
  output logic                    cfg_err
);

  logic [3:0]  opcode;
  logic [4:0]  half_idx;
  logic [15:0] half_val;
  logic [4:0]  new_rounds;
  logic [15:0] ctr_lo;
  logic        word_bad;

  // opcode sits in the same bits of both views
  assign opcode = cfg_word.load_fmt.opcode;
  assign half_idx = cfg_word.load_fmt.half_idx;
  assign half_val = cfg_word.load_fmt.half_val;
  assign new_rounds = cfg_word.ctrl_fmt.rounds;

  always_comb begin
    case (opcode)
      chacha_pkg::op_key: begin
        word_bad = (half_idx >= chacha_pkg::key_halves);
      end
      chacha_pkg::op_nonce: begin
        word_bad = (half_idx >= chacha_pkg::nonce_halves);
      end
      chacha_pkg::op_ctr: begin
        word_bad = (half_idx >= chacha_pkg::ctr_halves);
      end
      chacha_pkg::op_rounds: begin
        word_bad = !(new_rounds inside {5'd8, 5'd12, 5'd20});
      end
      default: begin
        word_bad = 1'b1;
      end
    endcase
  end

  // high half completes the counter, so the load fires with it
  assign ctr_load = cfg_valid && (opcode == chacha_pkg::op_ctr) &&
                    (half_idx == chacha_pkg::ctr_halves - 1);
  assign ctr_value = {half_val, ctr_lo};

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      key_state.key <= '0;
      key_state.nonce <= '0;
      key_state.rounds <= chacha_pkg::rounds_default;
      ctr_lo <= '0;
      cfg_err <= 1'b0;
    end else begin
      cfg_err <= cfg_valid && word_bad;
      if (cfg_valid && !word_bad) begin
        case (opcode)
          chacha_pkg::op_key: key_state.key[16*half_idx +: 16] <= half_val;
          chacha_pkg::op_nonce: key_state.nonce[16*half_idx +: 16] <= half_val;
          chacha_pkg::op_ctr: begin
            if (half_idx == '0) begin
              ctr_lo <= half_val;
            end
          end
          chacha_pkg::op_rounds: key_state.rounds <= new_rounds;
          default: begin
          end
        endcase
      end
    end
  end

  a_rounds_legal: assert property (@(posedge aclk) disable iff (!arst_n)
    key_state.rounds inside {5'd8, 5'd12, 5'd20})
    else $error("cfg_decode round count not 8, 12 or 20");

endmodule

//--- source/chacha_block_core.sv
`timescale 1ns/10ps

module chacha_block_core (
  input  logic                           aclk,
  input  logic                           arst_n,
  input  chacha_pkg::chacha_key_t        key_state,
  input  logic [31:0]                    counter,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  chacha_pkg::stream_beat_t       in_beat,
  output logic                           ks_valid,
  input  logic                           ks_ready,
  output logic [chacha_pkg::data_w-1:0]  keystream,
  output chacha_pkg::stream_beat_t       held_beat
);

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_round,
    st_final,
    st_hold
  } core_state_t;

  core_state_t state;
  logic [4:0]  round_cnt;

  // values sampled when the beat is accepted
  chacha_pkg::stream_beat_t beat_q;
  chacha_pkg::chacha_key_t  key_q;
  logic [31:0]              ctr_q;

  logic [15:0][31:0] x;
  logic [15:0][31:0] x_next;
  logic [15:0][31:0] init_state;
  logic              accept;

  function automatic logic [127:0] quarter_round(input logic [31:0] a,
                                                 input logic [31:0] b,
                                                 input logic [31:0] c,
                                                 input logic [31:0] d);
    logic [31:0] ta;
    logic [31:0] tb;
    logic [31:0] tc;
    logic [31:0] td;
    ta = a + b;
    td = d ^ ta;
    td = {td[15:0], td[31:16]};
    tc = c + td;
    tb = b ^ tc;
    tb = {tb[19:0], tb[31:20]};
    ta = ta + tb;
    td = td ^ ta;
    td = {td[23:0], td[31:24]};
    tc = tc + td;
    tb = tb ^ tc;
    tb = {tb[24:0], tb[31:25]};
    return {ta, tb, tc, td};
  endfunction

  assign in_ready = (state == st_idle);
  assign accept = in_valid && in_ready;
  assign ks_valid = (state == st_hold);
  assign keystream = x;
  assign held_beat = beat_q;

  // constants, key words, counter, nonce words
  always_comb begin
    init_state[3:0] = chacha_pkg::chacha_sigma;
    for (int i = 0; i < 8; i++) begin
      init_state[4+i] = key_q.key[32*i +: 32];
    end
    init_state[12] = ctr_q;
    for (int i = 0; i < 3; i++) begin
      init_state[13+i] = key_q.nonce[32*i +: 32];
    end
  end

  // even rounds work on columns, odd rounds on diagonals
  always_comb begin
    x_next = x;
    if (!round_cnt[0]) begin
      for (int i = 0; i < 4; i++) begin
        {x_next[i], x_next[4+i], x_next[8+i], x_next[12+i]} =
          quarter_round(x[i], x[4+i], x[8+i], x[12+i]);
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        {x_next[i], x_next[4+(i+1)%4], x_next[8+(i+2)%4], x_next[12+(i+3)%4]} =
          quarter_round(x[i], x[4+(i+1)%4], x[8+(i+2)%4], x[12+(i+3)%4]);
      end
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      round_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (in_valid) begin
            state <= st_load;
          end
        end
        st_load: begin
          state <= st_round;
          round_cnt <= '0;
        end
        st_round: begin
          round_cnt <= round_cnt + 1'b1;
          if (round_cnt == key_q.rounds - 5'd1) begin
            state <= st_final;
          end
        end
        st_final: state <= st_hold;
        st_hold: begin
          if (ks_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      beat_q <= in_beat;
      key_q <= key_state;
      ctr_q <= counter;
    end
    case (state)
      st_load: x <= init_state;
      st_round: x <= x_next;
      st_final: begin
        for (int i = 0; i < 16; i++) begin
          x[i] <= x[i] + init_state[i];
        end
      end
      default: begin
      end
    endcase
  end

  // no new beat until the current block has been handed off
  a_busy_no_accept: assert property (@(posedge aclk) disable iff (!arst_n)
    accept |=> !in_ready throughout (ks_valid && ks_ready)[->1])
    else $error("block_core accepted a beat while busy");

  a_ks_stable: assert property (@(posedge aclk) disable iff (!arst_n)
    ks_valid && !ks_ready |=> ks_valid && $stable(keystream) && $stable(held_beat))
    else $error("block_core keystream changed before handoff");

endmodule

//--- source/chacha_xor_result.sv
`timescale 1ns/10ps

module chacha_xor_result (
  input  logic                          aclk,
  input  logic                          arst_n,
  input  logic                          ks_valid,
  output logic                          ks_ready,
  input  logic [chacha_pkg::data_w-1:0] keystream,
  input  chacha_pkg::stream_beat_t      held_beat,
  input  logic                          ctr_load,
  input  logic [31:0]                   ctr_value,
  output logic [31:0]                   counter,
  output logic                          out_valid,
  input  logic                          out_ready,
  output chacha_pkg::stream_beat_t      out_beat
);

  logic accept;

  // single slot, refilled in the same cycle it drains
  assign ks_ready = !out_valid || out_ready;
  assign accept = ks_valid && ks_ready;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      out_beat.tdata <= held_beat.tdata ^ keystream;
      out_beat.tlast <= held_beat.tlast;
    end
  end

  // block counter, a config load beats the per-block step
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      counter <= '0;
    end else if (ctr_load) begin
      counter <= ctr_value;
    end else if (accept) begin
      counter <= counter + 32'd1;
    end
  end

  a_out_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("xor_result dropped out_valid before transfer");

endmodule

//--- source/chacha_stream_top.sv
`timescale 1ns/10ps

module chacha_stream_top (
  input  logic                     aclk,
  input  logic                     arst_n,
  input  logic                     cfg_valid,
  input  chacha_pkg::cfg_word_t    cfg_word,
  output logic                     cfg_err,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  chacha_pkg::stream_beat_t in_beat,
  output logic                     out_valid,
  input  logic                     out_ready,
  output chacha_pkg::stream_beat_t out_beat
);

  // input fifo to core
  logic                     core_valid;
  logic                     core_ready;
  chacha_pkg::stream_beat_t core_beat;

  // core to result stage
  logic                          ks_valid;
  logic                          ks_ready;
  logic [chacha_pkg::data_w-1:0] keystream;
  chacha_pkg::stream_beat_t      held_beat;

  // result stage to output fifo
  logic                     res_valid;
  logic                     res_ready;
  chacha_pkg::stream_beat_t res_beat;

  chacha_pkg::chacha_key_t key_state;
  logic                    ctr_load;
  logic [31:0]             ctr_value;
  logic [31:0]             counter;

  stream_fifo i_fifo_in (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (core_valid),
    .out_ready (core_ready),
    .out_beat  (core_beat)
  );

  chacha_cfg_decode i_decode (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .cfg_valid (cfg_valid),
    .cfg_word  (cfg_word),
    .key_state (key_state),
    .ctr_load  (ctr_load),
    .ctr_value (ctr_value),
    .cfg_err   (cfg_err)
  );

  chacha_block_core i_execute (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .key_state (key_state),
    .counter   (counter),
    .in_valid  (core_valid),
    .in_ready  (core_ready),
    .in_beat   (core_beat),
    .ks_valid  (ks_valid),
    .ks_ready  (ks_ready),
    .keystream (keystream),
    .held_beat (held_beat)
  );

  chacha_xor_result i_result (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .ks_valid  (ks_valid),
    .ks_ready  (ks_ready),
    .keystream (keystream),
    .held_beat (held_beat),
    .ctr_load  (ctr_load),
    .ctr_value (ctr_value),
    .counter   (counter),
    .out_valid (res_valid),
    .out_ready (res_ready),
    .out_beat  (res_beat)
  );

  stream_fifo i_fifo_out (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_valid  (res_valid),
    .in_ready  (res_ready),
    .in_beat   (res_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

endmodule

//--- verification/chacha_model.svh
`ifndef CHACHA_MODEL_SVH
`define CHACHA_MODEL_SVH

// rfc 8439 section 2.3.2 block test vector, word 0 in the low bits
localparam logic [255:0] rfc_key = {
  32'h1f1e1d1c, 32'h1b1a1918, 32'h17161514, 32'h13121110,
  32'h0f0e0d0c, 32'h0b0a0908, 32'h07060504, 32'h03020100
};
localparam logic [95:0] rfc_nonce = {32'h00000000, 32'h4a000000, 32'h09000000};
localparam logic [15:0][31:0] rfc_block = {
  32'h4e3c50a2, 32'he883d0cb, 32'hb94e16de, 32'hd19c12b5,
  32'ha2028bd9, 32'h05d7c214, 32'h09aa9f07, 32'h466482d2,
  32'h4e6cd4c3, 32'h9aaa2204, 32'h0368c033, 32'hc7f4d1c7,
  32'hc47120a3, 32'h1fdd0f50, 32'h15593bd1, 32'he4e7f110
};

function automatic logic [31:0] rotl32(input logic [31:0] v, input int n);
  return (v << n) | (v >> (32 - n));
endfunction

// one quarter round on four state words picked by index
function automatic logic [15:0][31:0] qr_model(input logic [15:0][31:0] s_in,
                                               input int a, input int b,
                                               input int c, input int d);
  logic [15:0][31:0] s;
  s = s_in;
  s[a] = s[a] + s[b];
  s[d] = rotl32(s[d] ^ s[a], 16);
  s[c] = s[c] + s[d];
  s[b] = rotl32(s[b] ^ s[c], 12);
  s[a] = s[a] + s[b];
  s[d] = rotl32(s[d] ^ s[a], 8);
  s[c] = s[c] + s[d];
  s[b] = rotl32(s[b] ^ s[c], 7);
  return s;
endfunction

// keystream block, rounds counts single column or diagonal rounds
function automatic logic [511:0] chacha_model_block(input logic [255:0] key,
                                                    input logic [31:0] ctr,
                                                    input logic [95:0] nonce,
                                                    input int rounds);
  logic [15:0][31:0] init;
  logic [15:0][31:0] w;
  init[0] = 32'h61707865;
  init[1] = 32'h3320646e;
  init[2] = 32'h79622d32;
  init[3] = 32'h6b206574;
  for (int i = 0; i < 8; i++) begin
    init[4+i] = key[32*i +: 32];
  end
  init[12] = ctr;
  for (int i = 0; i < 3; i++) begin
    init[13+i] = nonce[32*i +: 32];
  end
  w = init;
  for (int r = 0; r < rounds; r++) begin
    if (r % 2 == 0) begin
      w = qr_model(w, 0, 4, 8, 12);
      w = qr_model(w, 1, 5, 9, 13);
      w = qr_model(w, 2, 6, 10, 14);
      w = qr_model(w, 3, 7, 11, 15);
    end else begin
      w = qr_model(w, 0, 5, 10, 15);
      w = qr_model(w, 1, 6, 11, 12);
      w = qr_model(w, 2, 7, 8, 13);
      w = qr_model(w, 3, 4, 9, 14);
    end
  end
  for (int i = 0; i < 16; i++) begin
    w[i] = w[i] + init[i];
  end
  return w;
endfunction

// config word in the load view: opcode, half index, spare, half value
function automatic logic [31:0] make_load_word(input logic [3:0] op, input logic [4:0] idx,
                                               input logic [15:0] val);
  return {op, idx, 7'd0, val};
endfunction

function automatic logic [31:0] make_rounds_word(input logic [4:0] rounds);
  return {chacha_pkg::op_rounds, rounds, 23'd0};
endfunction

`endif

//--- verification/chacha_tb.sv
`timescale 1ns/10ps

module chacha_tb;

  localparam int clk_period = 20;
  localparam int total_beats = 31;
  localparam int watchdog_cycles = 40 * total_beats + 1000;

  logic                     aclk;
  logic                     arst_n;
  logic                     cfg_valid;
  chacha_pkg::cfg_word_t    cfg_word;
  logic                     cfg_err;
  logic                     in_valid;
  logic                     in_ready;
  chacha_pkg::stream_beat_t in_beat;
  logic                     out_valid;
  logic                     out_ready;
  chacha_pkg::stream_beat_t out_beat;

  // what the DUT should hold after our config writes
  logic [255:0] m_key;
  logic [95:0]  m_nonce;
  logic [31:0]  m_ctr;
  int           m_rounds;
  int           stall_pct;

  chacha_pkg::stream_beat_t send_q[$];
  chacha_pkg::stream_beat_t expect_q[$];

  `include "chacha_model.svh"

  chacha_stream_top i_dut (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .cfg_valid (cfg_valid),
    .cfg_word  (cfg_word),
    .cfg_err   (cfg_err),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  always #(clk_period / 2) aclk = ~aclk;

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string sig_name, input logic [575:0] expected,
                             input logic [575:0] actual);
    assert (expected === actual)
    else begin
      $display("FAIL %s expected %h actual %h", sig_name, expected, actual);
      abort_run();
    end
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired, the DUT stopped moving beats through the stream");
    abort_run();
  end

  function automatic logic [511:0] random_block();
    logic [511:0] r;
    for (int i = 0; i < 16; i++) begin
      r[32*i +: 32] = $urandom();
    end
    return r;
  endfunction

  // cfg_err answers one cycle after the strobe and is low again a cycle later
  task automatic cfg_write(input logic [31:0] word, input logic expect_err);
    @(negedge aclk);
    cfg_valid = 1'b1;
    cfg_word = word;
    @(negedge aclk);
    cfg_valid = 1'b0;
    check_value("cfg_err", expect_err, cfg_err);
    @(negedge aclk);
    check_value("cfg_err", 1'b0, cfg_err);
  endtask

  task automatic load_key(input logic [255:0] key);
    for (int j = 0; j < 16; j++) begin
      cfg_write(make_load_word(chacha_pkg::op_key, j[4:0], key[16*j +: 16]), 1'b0);
    end
    m_key = key;
  endtask

  task automatic load_nonce(input logic [95:0] nonce);
    for (int j = 0; j < 6; j++) begin
      cfg_write(make_load_word(chacha_pkg::op_nonce, j[4:0], nonce[16*j +: 16]), 1'b0);
    end
    m_nonce = nonce;
  endtask

  // the high half goes last because it fires the load
  task automatic load_ctr(input logic [31:0] ctr);
    cfg_write(make_load_word(chacha_pkg::op_ctr, 5'd0, ctr[15:0]), 1'b0);
    cfg_write(make_load_word(chacha_pkg::op_ctr, 5'd1, ctr[31:16]), 1'b0);
    m_ctr = ctr;
  endtask

  task automatic set_rounds(input int rounds);
    cfg_write(make_rounds_word(rounds[4:0]), 1'b0);
    m_rounds = rounds;
  endtask

  task automatic queue_beat(input logic [511:0] data, input logic last);
    chacha_pkg::stream_beat_t b;
    chacha_pkg::stream_beat_t e;
    b.tdata = data;
    b.tlast = last;
    e.tdata = data ^ chacha_model_block(m_key, m_ctr, m_nonce, m_rounds);
    e.tlast = last;
    send_q.push_back(b);
    expect_q.push_back(e);
    m_ctr = m_ctr + 32'd1;
  endtask

  task automatic drive_beats();
    @(negedge aclk);
    while (send_q.size() > 0) begin
      in_valid = 1'b1;
      in_beat = send_q.pop_front();
      while (!in_ready) begin
        @(negedge aclk);
      end
      @(negedge aclk);
    end
    in_valid = 1'b0;
  endtask

  // a beat seen here with out_ready high transfers on the next rising edge
  task automatic collect_beats();
    chacha_pkg::stream_beat_t e;
    int idx;
    idx = 0;
    while (expect_q.size() > 0) begin
      @(negedge aclk);
      out_ready = ($urandom_range(99) >= stall_pct);
      if (out_valid && out_ready) begin
        e = expect_q.pop_front();
        check_value($sformatf("out_beat.tdata[%0d]", idx), e.tdata, out_beat.tdata);
        check_value($sformatf("out_beat.tlast[%0d]", idx), e.tlast, out_beat.tlast);
        idx++;
      end
    end
    out_ready = 1'b1;
    @(negedge aclk);
    // nothing may be left over once every expected beat arrived
    check_value("out_valid", 1'b0, out_valid);
  endtask

  task automatic run_stream();
    fork
      drive_beats();
      collect_beats();
    join
  endtask

  task automatic test_reset_defaults();
    check_value("out_valid", 1'b0, out_valid);
    check_value("cfg_err", 1'b0, cfg_err);
    check_value("in_ready", 1'b1, in_ready);
    queue_beat(512'h0, 1'b0);
    run_stream();
  endtask

  task automatic test_rfc_vector();
    check_value("model block", rfc_block, chacha_model_block(rfc_key, 32'd1, rfc_nonce, 20));
    load_key(rfc_key);
    load_nonce(rfc_nonce);
    load_ctr(32'd1);
    set_rounds(20);
    queue_beat(random_block(), 1'b1);
    run_stream();
  endtask

  task automatic test_packet_order();
    load_ctr(32'h10);
    for (int k = 0; k < 6; k++) begin
      queue_beat(random_block(), k == 5);
    end
    run_stream();
  endtask

  task automatic test_round_change();
    set_rounds(12);
    load_ctr(32'h100);
    queue_beat(random_block(), 1'b1);
    run_stream();
    set_rounds(8);
    load_ctr(32'h200);
    queue_beat(random_block(), 1'b1);
    run_stream();
  endtask

  task automatic test_random_stalls();
    // drain slower than the core produces so back-pressure reaches the core
    stall_pct = 95;
    for (int k = 0; k < 20; k++) begin
      queue_beat(random_block(), $urandom_range(1));
    end
    run_stream();
    stall_pct = 0;
  endtask

  task automatic test_bad_config();
    cfg_write({4'hf, 28'h0}, 1'b1);
    cfg_write(make_load_word(chacha_pkg::op_nonce, 5'd6, 16'hbeef), 1'b1);
    cfg_write(make_rounds_word(5'd10), 1'b1);
    queue_beat(random_block(), 1'b1);
    run_stream();
  endtask

  initial begin : main_seq
    void'($urandom(32'h7910));
    aclk = 1'b0;
    arst_n = 1'b0;
    cfg_valid = 1'b0;
    cfg_word = '0;
    in_valid = 1'b0;
    in_beat = '0;
    out_ready = 1'b1;
    stall_pct = 0;
    m_key = '0;
    m_nonce = '0;
    m_ctr = '0;
    m_rounds = 8;
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;
    @(negedge aclk);
    test_reset_defaults();
    test_rfc_vector();
    test_packet_order();
    test_round_change();
    test_random_stalls();
    test_bad_config();
    $display("all tests passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+verification
source/chacha_pkg.sv
source/stream_fifo.sv
source/chacha_cfg_decode.sv
source/chacha_block_core.sv
source/chacha_xor_result.sv
source/chacha_stream_top.sv
verification/chacha_tb.sv
